/* hw/mipsExPkg.sv */
package mipsExPkg;

	////////////////////////////////////////////////////////////
	// Execute opcodes
	////////////////////////////////////////////////////////////

	// Bit 4 set marks the multiply/divide class
	typedef enum logic [4:0] {
		opAddu  = 5'd0,
		opSubu  = 5'd1,
		opAnd   = 5'd2,
		opOr    = 5'd3,
		opXor   = 5'd4,
		opNor   = 5'd5,
		opSlt   = 5'd6,
		opSltu  = 5'd7,
		opSll   = 5'd8,
		opSrl   = 5'd9,
		opSra   = 5'd10,
		opLui   = 5'd11,
		opMult  = 5'd16,
		opMultu = 5'd17,
		opDiv   = 5'd18,
		opDivu  = 5'd19,
		opMthi  = 5'd20,
		opMtlo  = 5'd21,
		opMfhi  = 5'd22,
		opMflo  = 5'd23
	} exOp_e;

	////////////////////////////////////////////////////////////
	// Stage interfaces
	////////////////////////////////////////////////////////////

	// One instruction from decode, operand B already extended
	typedef struct packed {
		exOp_e       op;
		logic [31:0] srcA;
		logic [31:0] srcB;
		logic [4:0]  shamt;    // Shift amount field
		logic [4:0]  dest;     // Destination register
		logic [31:0] pc;
	} exIssue_t;

	// Register file write report, same shape as w_grf_*
	typedef struct packed {
		logic        we;
		logic [4:0]  addr;
		logic [31:0] data;
		logic [31:0] pc;
	} wbTrace_t;

endpackage

/* hw/alu.sv */
module alu (
	input  mipsExPkg::exIssue_t issue,
	output logic [31:0]         aluOut
);
	import mipsExPkg::*;

	logic [31:0] a;
	logic [31:0] b;

	assign a = issue.srcA;
	assign b = issue.srcB;

	always_comb begin
		case (issue.op)
			opAddu: begin
				aluOut = a + b;    // Wraps, no overflow trap
			end
			opSubu: begin
				aluOut = a - b;
			end
			opAnd: begin
				aluOut = a & b;
			end
			opOr: begin
				aluOut = a | b;
			end
			opXor: begin
				aluOut = a ^ b;
			end
			opNor: begin
				aluOut = ~(a | b);
			end
			opSlt: begin
				aluOut = {31'd0, $signed(a) < $signed(b)};
			end
			opSltu: begin
				aluOut = {31'd0, a < b};
			end
			// Shifts act on operand B, as in the MIPS encoding
			opSll: begin
				aluOut = b << issue.shamt;
			end
			opSrl: begin
				aluOut = b >> issue.shamt;
			end
			opSra: begin
				aluOut = $signed(b) >>> issue.shamt;
			end
			opLui: begin
				aluOut = {b[15:0], 16'd0};
			end
			default: begin
				aluOut = 32'd0;    // MDU class
			end
		endcase
	end

endmodule

/* hw/mdu.sv */
module mdu #(
	parameter int MultLatency = 5,
	parameter int DivLatency  = 10
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                issueValid,
	input  mipsExPkg::exIssue_t issue,
	output logic [31:0]         mduOut,
	output logic                busy
);
	import mipsExPkg::*;

	localparam int MaxLatency = (MultLatency > DivLatency) ? MultLatency : DivLatency;
	localparam int CountWidth = $clog2(MaxLatency + 1);

	logic [31:0]           hi;
	logic [31:0]           lo;
	logic [31:0]           pendHi;        // Result waiting for the count to end
	logic [31:0]           pendLo;
	logic                  pendCommit;    // Low after a divide by zero
	logic [CountWidth-1:0] count;
	logic                  startMult;
	logic                  startDiv;
	logic                  divByZero;
	logic [31:0]           divisor;
	logic signed [63:0]    aSext;
	logic signed [63:0]    bSext;
	logic [63:0]           prodSigned;
	logic [63:0]           prodUnsigned;
	logic [31:0]           quotSigned;
	logic [31:0]           remSigned;
	logic [31:0]           quotUnsigned;
	logic [31:0]           remUnsigned;

	assign startMult = issueValid && (issue.op == opMult || issue.op == opMultu);
	assign startDiv  = issueValid && (issue.op == opDiv || issue.op == opDivu);

	////////////////////////////////////////////////////////////
	// Arithmetic on the issued operands
	////////////////////////////////////////////////////////////

	assign aSext        = {{32{issue.srcA[31]}}, issue.srcA};
	assign bSext        = {{32{issue.srcB[31]}}, issue.srcB};
	assign prodSigned   = aSext * bSext;
	assign prodUnsigned = {32'd0, issue.srcA} * {32'd0, issue.srcB};

	assign divByZero = (issue.srcB == 32'd0);
	assign divisor   = divByZero ? 32'd1 : issue.srcB;    // Result is dropped anyway

	assign quotSigned   = $signed(issue.srcA) / $signed(divisor);
	assign remSigned    = $signed(issue.srcA) % $signed(divisor);
	assign quotUnsigned = issue.srcA / divisor;
	assign remUnsigned  = issue.srcA % divisor;

	always_ff @(posedge clk) begin
		if (startMult) begin
			{pendHi, pendLo} <= (issue.op == opMult) ? prodSigned : prodUnsigned;
		end else if (startDiv) begin
			pendHi <= (issue.op == opDiv) ? remSigned : remUnsigned;
			pendLo <= (issue.op == opDiv) ? quotSigned : quotUnsigned;
		end
	end

	////////////////////////////////////////////////////////////
	// Latency countdown
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			count      <= '0;
			pendCommit <= 1'b0;
		end else if (startMult) begin
			count      <= CountWidth'(MultLatency);
			pendCommit <= 1'b1;
		end else if (startDiv) begin
			count      <= CountWidth'(DivLatency);
			pendCommit <= !divByZero;
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	assign busy = (count != '0);

	// HI/LO update on the edge where busy drops
	always_ff @(posedge clk) begin
		if (reset) begin
			hi <= 32'd0;
			lo <= 32'd0;
		end else if (count == CountWidth'(1) && pendCommit) begin
			hi <= pendHi;
			lo <= pendLo;
		end else if (issueValid && issue.op == opMthi) begin
			hi <= issue.srcA;
		end else if (issueValid && issue.op == opMtlo) begin
			lo <= issue.srcA;
		end
	end

	assign mduOut = (issue.op == opMfhi) ? hi : lo;

endmodule

/* hw/exResult.sv */
module exResult (
	input  logic                clk,
	input  logic                reset,
	input  logic                issueValid,
	input  mipsExPkg::exIssue_t issue,
	input  logic [31:0]         aluOut,
	input  logic [31:0]         mduOut,
	output mipsExPkg::wbTrace_t trace
);
	import mipsExPkg::*;

	logic        selAlu;      // ALU result goes to the register file
	logic        selHiLo;     // mfhi or mflo
	logic        writes;
	logic [31:0] resultData;

	////////////////////////////////////////////////////////////
	// Opcode classification
	////////////////////////////////////////////////////////////

	always_comb begin
		selAlu  = 1'b0;
		selHiLo = 1'b0;
		case (issue.op)
			opAddu, opSubu, opAnd, opOr, opXor, opNor,
			opSlt, opSltu, opSll, opSrl, opSra, opLui: begin
				selAlu = 1'b1;
			end
			opMfhi, opMflo: begin
				selHiLo = 1'b1;
			end
			default: begin
				// Multiply, divide, mthi, mtlo write nothing here
				selAlu  = 1'b0;
				selHiLo = 1'b0;
			end
		endcase
	end

	assign resultData = selHiLo ? mduOut : aluOut;
	assign writes     = issueValid && (selAlu || selHiLo) && (issue.dest != 5'd0);

	////////////////////////////////////////////////////////////
	// Stage register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		trace.addr <= issue.dest;
		trace.data <= resultData;
		trace.pc   <= issue.pc;
		if (reset) begin
			trace.we <= 1'b0;
		end else begin
			trace.we <= writes;    // One-cycle pulse per write
		end
	end

endmodule

/* hw/exStage.sv */
module exStage #(
	parameter int MultLatency = 5,
	parameter int DivLatency  = 10
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                issueValid,
	input  mipsExPkg::exIssue_t issue,
	output logic                busy,
	output mipsExPkg::wbTrace_t trace
);
	import mipsExPkg::*;

	logic [31:0] aluOut;
	logic [31:0] mduOut;    // HI or LO, picked by the opcode

	alu uAlu (
		.issue  (issue),
		.aluOut (aluOut)
	);

	// Runs beside the ALU, ALU ops keep flowing while busy
	mdu #(
		.MultLatency (MultLatency),
		.DivLatency  (DivLatency)
	) uMdu (
		.clk        (clk),
		.reset      (reset),
		.issueValid (issueValid),
		.issue      (issue),
		.mduOut     (mduOut),
		.busy       (busy)
	);

	exResult uResult (
		.clk        (clk),
		.reset      (reset),
		.issueValid (issueValid),
		.issue      (issue),
		.aluOut     (aluOut),
		.mduOut     (mduOut),
		.trace      (trace)
	);

endmodule

/* verification/exStage_sva.sv */
module exStageSva (
	input logic                clk,
	input logic                reset,
	input logic                issueValid,
	input mipsExPkg::exIssue_t issue,
	input logic                busy,
	input mipsExPkg::wbTrace_t trace
);
	import mipsExPkg::*;

	logic mduIssue;

	assign mduIssue = issueValid && (issue.op inside {opMult, opMultu, opDiv, opDivu,
		opMthi, opMtlo, opMfhi, opMflo});

	// Stage comes out of reset idle
	resetIdle: assert property (@(posedge clk) reset |=> (!busy && !trace.we))
		else $error("busy or trace.we set after reset");

	// MDU work must wait for busy to drop
	noMduWhileBusy: assert property (@(posedge clk) disable iff (reset) busy |-> !mduIssue)
		else $error("MDU instruction issued while busy");

endmodule

bind exStage exStageSva uSva (
	.clk        (clk),
	.reset      (reset),
	.issueValid (issueValid),
	.issue      (issue),
	.busy       (busy),
	.trace      (trace)
);

/* verification/exStageTb.sv */
module exStageTb;
	import mipsExPkg::*;

	localparam int MultLatency = 5;
	localparam int DivLatency  = 10;
	localparam int BusyTimeout = 40;    // Cycles before a busy wait gives up

	logic     clk;
	logic     reset;
	logic     issueValid;
	exIssue_t issue;
	logic     busy;
	wbTrace_t trace;

	integer      seed;
	int          errors;
	int          timeouts;
	int          checks;
	logic        busySeen;    // busy as sampled after the last edge
	logic [31:0] modelHi;
	logic [31:0] modelLo;
	logic [31:0] pcNext;
	wbTrace_t    expected[$];

	exStage #(
		.MultLatency (MultLatency),
		.DivLatency  (DivLatency)
	) uut (
		.clk        (clk),
		.reset      (reset),
		.issueValid (issueValid),
		.issue      (issue),
		.busy       (busy),
		.trace      (trace)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] aluModel(exIssue_t ins);
		int sa;
		int sb;
		sa = ins.srcA;
		sb = ins.srcB;
		case (ins.op)
			opAddu:  return ins.srcA + ins.srcB;
			opSubu:  return ins.srcA - ins.srcB;
			opAnd:   return ins.srcA & ins.srcB;
			opOr:    return ins.srcA | ins.srcB;
			opXor:   return ins.srcA ^ ins.srcB;
			opNor:   return ~(ins.srcA | ins.srcB);
			opSlt:   return (sa < sb) ? 32'd1 : 32'd0;
			opSltu:  return (ins.srcA < ins.srcB) ? 32'd1 : 32'd0;
			opSll:   return ins.srcB << ins.shamt;
			opSrl:   return ins.srcB >> ins.shamt;
			opSra:   return sb >>> ins.shamt;    // int keeps the sign
			opLui:   return ins.srcB << 16;
			default: return 32'd0;
		endcase
	endfunction

	// Applies one issue to HI/LO and returns the trace it should produce
	function automatic wbTrace_t modelStep(exIssue_t ins);
		wbTrace_t        want;
		int              sa;
		int              sb;
		longint unsigned ua;
		longint unsigned ub;
		sa = ins.srcA;
		sb = ins.srcB;
		ua = ins.srcA;
		ub = ins.srcB;
		want = '0;
		want.addr = ins.dest;
		want.pc = ins.pc;
		case (ins.op)
			opMult:  {modelHi, modelLo} = longint'(sa) * longint'(sb);
			opMultu: {modelHi, modelLo} = ua * ub;
			opDiv: begin
				if (sb != 0) begin    // Zero divisor keeps HI and LO
					modelLo = sa / sb;
					modelHi = sa % sb;
				end
			end
			opDivu: begin
				if (ub != 0) begin
					modelLo = ins.srcA / ins.srcB;
					modelHi = ins.srcA % ins.srcB;
				end
			end
			opMthi:  modelHi = ins.srcA;
			opMtlo:  modelLo = ins.srcA;
			opMfhi:  want.data = modelHi;
			opMflo:  want.data = modelLo;
			default: want.data = aluModel(ins);
		endcase
		want.we = (ins.op <= opLui || ins.op == opMfhi || ins.op == opMflo) && ins.dest != 5'd0;
		return want;
	endfunction

	////////////////////////////////////////////////////////////
	// Stimulus and checks
	////////////////////////////////////////////////////////////

	function automatic exIssue_t randomAlu();
		exIssue_t    ins;
		logic [31:0] r;
		r = $random(seed);
		ins.op    = exOp_e'(5'(r[7:0] % 8'd12));
		ins.srcA  = $random(seed);
		ins.srcB  = $random(seed);
		ins.shamt = r[12:8];
		ins.dest  = r[17:13];
		ins.pc    = pcNext;
		pcNext    = pcNext + 32'd4;
		return ins;
	endfunction

	function automatic exIssue_t makeIssue(exOp_e op, logic [31:0] a, logic [31:0] b);
		exIssue_t ins;
		ins = randomAlu();
		ins.op   = op;
		ins.srcA = a;
		ins.srcB = b;
		ins.dest = ins.dest | 5'd1;    // Odd register so HI/LO reads always show
		return ins;
	endfunction

	task automatic checkTrace(input wbTrace_t want);
		checks++;
		assert (trace.we === want.we) else begin
			errors++;
			$display("FAIL trace.we: got %h, expected %h at pc %h", trace.we, want.we, want.pc);
		end
		if (want.we) begin
			assert (trace.addr === want.addr) else begin
				errors++;
				$display("FAIL trace.addr: got %h, expected %h", trace.addr, want.addr);
			end
			assert (trace.data === want.data) else begin
				errors++;
				$display("FAIL trace.data: got %h, expected %h", trace.data, want.data);
			end
			assert (trace.pc === want.pc) else begin
				errors++;
				$display("FAIL trace.pc: got %h, expected %h", trace.pc, want.pc);
			end
		end
	endtask

	// Called 2 units after an edge, returns 2 units after the next one
	task automatic driveIssue(input logic valid, input exIssue_t ins);
		wbTrace_t want;
		want = '0;
		issueValid = valid;
		issue = ins;
		if (valid) begin
			want = modelStep(ins);
		end
		expected.push_back(want);
		@(posedge clk);
		#1;
		busySeen = busy;
		checkTrace(expected.pop_front());
		#1;
	endtask

	task automatic finishRun();
		$display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	endtask

	task automatic mduRound(input exOp_e op, input logic [31:0] a, input logic [31:0] b);
		int busyCycles;
		int latency;
		busyCycles = 0;
		case (op)
			opMult, opMultu: latency = MultLatency;
			opDiv, opDivu:   latency = DivLatency;
			default:         latency = 0;
		endcase
		driveIssue(1'b1, makeIssue(op, a, b));
		while (busySeen) begin
			busyCycles++;
			if (busyCycles > BusyTimeout) begin
				timeouts++;
				$display("Timed out waiting for busy to fall after %s", op.name());
				return;
			end
			driveIssue(1'b1, randomAlu());    // ALU work keeps retiring
		end
		assert (busyCycles == latency) else begin
			errors++;
			$display("FAIL busy cycles: got %h, expected %h", busyCycles, latency);
		end
		driveIssue(1'b1, makeIssue(opMfhi, 32'd0, 32'd0));
		driveIssue(1'b1, makeIssue(opMflo, 32'd0, 32'd0));
	endtask

	initial begin
		int          i;
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] b;
		exIssue_t    ins;
		seed = 32'h8efa_a7f2;
		errors = 0;
		timeouts = 0;
		checks = 0;
		modelHi = 32'd0;
		modelLo = 32'd0;
		pcNext = 32'h0040_0000;
		busySeen = 1'b0;
		reset = 1'b1;
		issueValid = 1'b0;
		issue = '0;
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;

		// ALU stream with idle gaps and writes to register zero
		for (i = 0; i < 300; i++) begin
			ins = randomAlu();
			if (i % 9 == 0) begin
				ins.dest = 5'd0;
			end
			driveIssue(i % 7 != 3, ins);
		end

		// Opcodes 16 to 23 cover the whole MDU class
		for (i = 0; i < 60; i++) begin
			r = $random(seed);
			a = $random(seed);
			b = r[3] ? $random(seed) : {24'd0, r[15:8]};    // Small divisors
			if (r[7:5] == 3'd0) begin
				b = 32'd0;
			end
			if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
				b = 32'd1;    // Signed overflow case left out
			end
			mduRound(exOp_e'(5'd16 + 5'(r[2:0])), a, b);
			if (timeouts != 0) begin
				break;
			end
		end
		finishRun();
	end

endmodule

/* flist.f */
hw/mipsExPkg.sv
hw/alu.sv
hw/mdu.sv
hw/exResult.sv
hw/exStage.sv
verification/exStage_sva.sv
verification/exStageTb.sv

/* run.sh */
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module exStageTb -o simExStage
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simExStage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "tests failed" "$LOG"; then
	exit 1
fi
exit 0
